// File: fe_macros.svh
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// Data and address width.
`define FE_XLEN 32

// First fetch address after reset.
`define FE_RESET_PC 32'h8000_0000

// Iterations per multiply or divide.
`define FE_MD_CYCLES 32

`endif

// File: fe_pkg.sv
`default_nettype none

package fe_pkg;

    // RV32 major opcodes that the front end reacts to.
    typedef enum logic [6:0] {
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_op     = 7'b0110011,
        op_other  = 7'b0010011  // Op-imm stands in for any non-control word.
    } opcode_e;

    typedef enum logic [2:0] {
        br_beq = 3'b000,
        br_bne = 3'b001,
        br_blt = 3'b100,
        br_bge = 3'b101
    } br_funct_e;

    typedef enum logic {
        md_mul  = 1'b0,
        md_divu = 1'b1
    } md_op_e;

    typedef enum logic [1:0] {
        idle,
        wait_mem,
        done
    } fetch_state_e;

    typedef enum logic [1:0] {
        md_idle,
        md_run,
        md_finish
    } md_state_e;

endpackage

`default_nettype wire

// File: fetch_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "fe_macros.svh"

interface fetch_if;

    logic [`FE_XLEN-1:0] pc;       // Next fetch address.
    logic [`FE_XLEN-1:0] inst;
    logic [`FE_XLEN-1:0] inst_pc;  // Address the word was read from.
    logic                r_done;   // One cycle per returned word.

    modport pcgen (
        output pc,
        input  r_done
    );

    modport fetch (
        input  pc,
        output inst,
        output inst_pc,
        output r_done
    );

    modport decode (
        input  inst,
        input  inst_pc,
        input  r_done
    );

endinterface

`default_nettype wire

// File: redirect_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "fe_macros.svh"

interface redirect_if;

    logic                jalr_wait;  // Jalr seen, target follows next cycle.
    logic                redirect;
    logic [`FE_XLEN-1:0] target;
    logic                hold;       // Mul/divu in flight.

    modport decode (
        output jalr_wait,
        output redirect,
        output target,
        output hold
    );

    modport pcgen (
        input  jalr_wait,
        input  redirect,
        input  target,
        input  hold
    );

endinterface

`default_nettype wire

// File: pc_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "fe_macros.svh"

module pc_gen (
    input  wire       clk,
    input  wire       rst_n,
    fetch_if.pcgen    fif,
    redirect_if.pcgen rif
);

    logic [`FE_XLEN-1:0] curr_pc;
    logic                jalr_d;
    logic                hold_d;
    logic                pc_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_d <= 1'b0;
            hold_d <= 1'b0;
        end else begin
            jalr_d <= rif.jalr_wait;
            hold_d <= rif.hold;
        end
    end

    // Falling hold marks the finish cycle of a mul/divu.
    assign pc_en = fif.r_done | jalr_d | (hold_d & ~rif.hold);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= `FE_RESET_PC;
        end else if (pc_en) begin
            if (rif.hold) begin
                curr_pc <= curr_pc;
            end else if (rif.jalr_wait) begin
                curr_pc <= curr_pc;  // Rs1 is sampled this cycle.
            end else if (jalr_d || rif.redirect) begin
                curr_pc <= rif.target;
            end else begin
                curr_pc <= curr_pc + `FE_XLEN'(4);
            end
        end
    end

    assign fif.pc = curr_pc;

    // A held instruction can never also be a control transfer.
    a_no_redirect_in_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rif.redirect && rif.hold)
    );

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "fe_macros.svh"

module fetch_unit (
    input  wire                 clk,
    input  wire                 rst_n,
    output logic                imem_req,
    output logic [`FE_XLEN-1:0] imem_addr,
    input  wire  [`FE_XLEN-1:0] imem_rdata,
    input  wire                 imem_rvalid,
    fetch_if.fetch              fif,
    input  wire                 rif_hold,
    input  wire                 jalr_busy
);

    fe_pkg::fetch_state_e state;
    logic                 hold_q;
    logic                 jalr_q;
    logic                 stall;

    // The PC settles one cycle after hold drops or a jalr resolves.
    assign stall = rif_hold | hold_q | jalr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= fe_pkg::idle;
            imem_req <= 1'b0;
            hold_q   <= 1'b0;
            jalr_q   <= 1'b0;
        end else begin
            hold_q <= rif_hold;
            jalr_q <= jalr_busy;
            case (state)
                fe_pkg::idle: begin
                    if (!stall) begin
                        imem_req <= 1'b1;
                        state    <= fe_pkg::wait_mem;
                    end
                end
                fe_pkg::wait_mem: begin
                    if (imem_rvalid) begin
                        imem_req <= 1'b0;
                        state    <= fe_pkg::done;
                    end
                end
                default: begin
                    state <= fe_pkg::idle;  // Done lasts one cycle.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fe_pkg::idle && !stall) begin
            imem_addr <= fif.pc;
        end
        if (state == fe_pkg::wait_mem && imem_rvalid) begin
            fif.inst    <= imem_rdata;
            fif.inst_pc <= imem_addr;
        end
    end

    assign fif.r_done = (state == fe_pkg::done);

    // Memory sees one steady address for the whole outstanding read.
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        imem_req && !imem_rvalid |=> imem_req && $stable(imem_addr)
    );

endmodule

`default_nettype wire

// File: redirect_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "fe_macros.svh"

module redirect_decode (
    input  wire                 clk,
    input  wire                 rst_n,
    fetch_if.decode             fif,
    redirect_if.decode          rif,
    input  wire  [`FE_XLEN-1:0] rs1_data,
    input  wire  [`FE_XLEN-1:0] rs2_data,
    output logic                start,
    output fe_pkg::md_op_e      op,
    input  wire                 finish
);

    fe_pkg::opcode_e     opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`FE_XLEN-1:0] imm_i;
    logic [`FE_XLEN-1:0] imm_b;
    logic [`FE_XLEN-1:0] imm_j;
    logic                br_taken;
    logic                is_jal;
    logic                is_md;
    logic                jalr_pend;
    logic [`FE_XLEN-1:0] jalr_base;
    logic [`FE_XLEN-1:0] jalr_ofs;
    logic [`FE_XLEN-1:0] jalr_sum;
    logic                md_busy;

    assign opcode = fe_pkg::opcode_e'(fif.inst[6:0]);
    assign funct3 = fif.inst[14:12];
    assign funct7 = fif.inst[31:25];

    assign imm_i = {{(`FE_XLEN-12){fif.inst[31]}}, fif.inst[31:20]};
    assign imm_b = {{(`FE_XLEN-12){fif.inst[31]}}, fif.inst[7], fif.inst[30:25],
                    fif.inst[11:8], 1'b0};
    assign imm_j = {{(`FE_XLEN-20){fif.inst[31]}}, fif.inst[19:12], fif.inst[20],
                    fif.inst[30:21], 1'b0};

    always_comb begin
        case (funct3)
            fe_pkg::br_beq: br_taken = (rs1_data == rs2_data);
            fe_pkg::br_bne: br_taken = (rs1_data != rs2_data);
            fe_pkg::br_blt: br_taken = ($signed(rs1_data) < $signed(rs2_data));
            fe_pkg::br_bge: br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            default:        br_taken = 1'b0;
        endcase
    end

    assign is_jal = (opcode == fe_pkg::op_jal);

    // Only mul (000) and divu (101) of the M extension are handled.
    assign is_md = (opcode == fe_pkg::op_op) && (funct7 == 7'b0000001) &&
                   (funct3 == 3'b000 || funct3 == 3'b101);

    assign rif.jalr_wait = fif.r_done && (opcode == fe_pkg::op_jalr);
    assign rif.redirect  = jalr_pend |
                           (fif.r_done & (is_jal | (opcode == fe_pkg::op_branch && br_taken)));

    assign jalr_sum = jalr_base + jalr_ofs;

    always_comb begin
        if (jalr_pend)
            rif.target = {jalr_sum[`FE_XLEN-1:1], 1'b0};
        else if (is_jal)
            rif.target = fif.inst_pc + imm_j;
        else
            rif.target = fif.inst_pc + imm_b;
    end

    assign start    = fif.r_done & is_md;
    assign op       = funct3[2] ? fe_pkg::md_divu : fe_pkg::md_mul;
    assign rif.hold = start | (md_busy & ~finish);  // Drops in the finish cycle.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_pend <= 1'b0;
            md_busy   <= 1'b0;
        end else begin
            jalr_pend <= rif.jalr_wait;
            if (start)
                md_busy <= 1'b1;
            else if (finish)
                md_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rif.jalr_wait) begin
            jalr_base <= rs1_data;
            jalr_ofs  <= imm_i;
        end
    end

endmodule

`default_nettype wire

// File: muldiv_seq.sv
`timescale 1ns/1ps
`default_nettype none
`include "fe_macros.svh"

module muldiv_seq (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start,
    input  wire fe_pkg::md_op_e op,
    input  wire  [`FE_XLEN-1:0] a,
    input  wire  [`FE_XLEN-1:0] b,
    output logic                finish,
    output logic [`FE_XLEN-1:0] result
);

    localparam int CNT_W = $clog2(`FE_MD_CYCLES);

    fe_pkg::md_state_e   state;
    fe_pkg::md_op_e      op_q;
    logic [CNT_W-1:0]    cnt;
    logic [`FE_XLEN-1:0] acc;   // Product, or partial remainder.
    logic [`FE_XLEN-1:0] opa;   // Multiplicand, or dividend turning into quotient.
    logic [`FE_XLEN-1:0] opb;   // Multiplier, or divisor.
    logic [`FE_XLEN:0]   rem_shift;
    logic [`FE_XLEN:0]   diff;

    assign rem_shift = {acc, opa[`FE_XLEN-1]};
    assign diff      = rem_shift - {1'b0, opb};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fe_pkg::md_idle;
            cnt   <= '0;
        end else begin
            case (state)
                fe_pkg::md_idle: begin
                    if (start) begin
                        state <= fe_pkg::md_run;
                        cnt   <= '0;
                    end
                end
                fe_pkg::md_run: begin
                    cnt <= cnt + CNT_W'(1);
                    if (cnt == CNT_W'(`FE_MD_CYCLES - 1))
                        state <= fe_pkg::md_finish;
                end
                default: begin
                    state <= fe_pkg::md_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fe_pkg::md_idle && start) begin
            op_q <= op;
            acc  <= '0;
            opa  <= a;
            opb  <= b;
        end else if (state == fe_pkg::md_run) begin
            if (op_q == fe_pkg::md_mul) begin
                if (opb[0])
                    acc <= acc + opa;
                opa <= opa << 1;
                opb <= opb >> 1;
            end else if (!diff[`FE_XLEN]) begin
                acc <= diff[`FE_XLEN-1:0];  // Divisor fits, keep the difference.
                opa <= {opa[`FE_XLEN-2:0], 1'b1};
            end else begin
                acc <= rem_shift[`FE_XLEN-1:0];
                opa <= {opa[`FE_XLEN-2:0], 1'b0};
            end
        end
    end

    // A zero divisor always fits, so the quotient comes out all ones.
    assign finish = (state == fe_pkg::md_finish);
    assign result = (op_q == fe_pkg::md_mul) ? acc : opa;

    // The decoder holds fetch, so no new mul/divu can reach us mid-run.
    a_no_restart: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> state == fe_pkg::md_idle
    );

endmodule

`default_nettype wire

// File: fe_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fe_macros.svh"

module fe_top (
    input  wire                 clk,
    input  wire                 rst_n,
    output logic                imem_req,
    output logic [`FE_XLEN-1:0] imem_addr,
    input  wire  [`FE_XLEN-1:0] imem_rdata,
    input  wire                 imem_rvalid,
    input  wire  [`FE_XLEN-1:0] rs1_data,
    input  wire  [`FE_XLEN-1:0] rs2_data,
    output logic                md_valid,
    output logic [`FE_XLEN-1:0] md_result,
    output logic                inst_valid,
    output logic [`FE_XLEN-1:0] inst_pc
);

    fetch_if    fif ();
    redirect_if rif ();

    logic           md_start;
    logic           md_finish;
    fe_pkg::md_op_e md_op;

    pc_gen u_pc_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .fif   (fif.pcgen),
        .rif   (rif.pcgen)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .imem_rvalid (imem_rvalid),
        .fif         (fif.fetch),
        .rif_hold    (rif.hold),
        .jalr_busy   (rif.jalr_wait)
    );

    redirect_decode u_redirect_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .fif      (fif.decode),
        .rif      (rif.decode),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .start    (md_start),
        .op       (md_op),
        .finish   (md_finish)
    );

    // Operands are sampled by the unit on the start edge.
    muldiv_seq u_muldiv_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (md_start),
        .op     (md_op),
        .a      (rs1_data),
        .b      (rs2_data),
        .finish (md_finish),
        .result (md_result)
    );

    assign md_valid   = md_finish;
    assign inst_valid = fif.r_done;
    assign inst_pc    = fif.inst_pc;

endmodule

`default_nettype wire

// File: tb_fe_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fe_macros.svh"

module tb_fe_top;

    localparam int                  WAIT_LIMIT = 200;
    localparam logic [`FE_XLEN-1:0] RESET_PC   = `FE_RESET_PC;

    logic                clk;
    logic                rst_n;
    logic                imem_req;
    logic [`FE_XLEN-1:0] imem_addr;
    logic [`FE_XLEN-1:0] imem_rdata;
    logic                imem_rvalid;
    logic [`FE_XLEN-1:0] rs1_data;
    logic [`FE_XLEN-1:0] rs2_data;
    logic                md_valid;
    logic [`FE_XLEN-1:0] md_result;
    logic                inst_valid;
    logic [`FE_XLEN-1:0] inst_pc;

    logic [`FE_XLEN-1:0] prog [logic [`FE_XLEN-1:0]];  // Sparse program image.
    logic                mem_busy;
    int unsigned         mem_delay;

    fe_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .imem_rvalid (imem_rvalid),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .md_valid    (md_valid),
        .md_result   (md_result),
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc)
    );

    always #2 clk = ~clk;

    // Instruction memory that answers 1 to 4 cycles after it sees a request.
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_busy    <= 1'b0;
            imem_rvalid <= 1'b0;
        end else begin
            imem_rvalid <= 1'b0;
            if (imem_req && !mem_busy && !imem_rvalid) begin
                mem_busy  <= 1'b1;
                mem_delay <= $urandom_range(3, 0);
            end else if (mem_busy) begin
                if (mem_delay == 0) begin
                    imem_rvalid <= 1'b1;
                    imem_rdata  <= read_word(imem_addr);
                    mem_busy    <= 1'b0;
                end else begin
                    mem_delay <= mem_delay - 1;
                end
            end
        end
    end

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (prog.exists(addr))
            return prog[addr];
        return {addr[31:7] ^ {addr[6:0], addr[24:7]}, fe_pkg::op_other};  // Op-imm filler.
    endfunction

    function automatic logic [31:0] enc_jal(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, fe_pkg::op_jal};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [31:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], fe_pkg::op_branch};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [31:0] imm);
        return {imm[11:0], 5'd1, 3'b000, 5'd0, fe_pkg::op_jalr};
    endfunction

    function automatic logic [31:0] enc_md(input logic [2:0] f3);
        return {7'b0000001, 5'd2, 5'd1, f3, 5'd3, fe_pkg::op_op};
    endfunction

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        stop_run();
    endtask

    task automatic start_program(input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        rst_n    <= 1'b0;
        rs1_data <= a;
        rs2_data <= b;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Waits for the next returned word and checks where it came from.
    task automatic next_fetch(input logic [31:0] exp_pc);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!inst_valid) begin
            cycles++;
            if (cycles == WAIT_LIMIT)
                timed_out("inst_valid");
            @(negedge clk);
        end
        check_value("inst_pc", inst_pc, exp_pc);
    endtask

    task automatic run_jal(input logic [31:0] off);
        prog.delete();
        prog[RESET_PC] = enc_jal(off);
        start_program(0, 0);
        next_fetch(RESET_PC);
        next_fetch(RESET_PC + off);
        next_fetch(RESET_PC + off + 4);
    endtask

    task automatic run_branch(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] off, input logic taken);
        logic [31:0] dest;
        dest = taken ? RESET_PC + off : RESET_PC + 4;
        prog.delete();
        prog[RESET_PC] = enc_branch(f3, off);
        start_program(a, b);
        next_fetch(RESET_PC);
        next_fetch(dest);
        next_fetch(dest + 4);
    endtask

    task automatic run_jalr(input logic [31:0] base, input logic [31:0] imm);
        logic [31:0] dest;
        dest = (base + {{20{imm[11]}}, imm[11:0]}) & ~32'd1;
        prog.delete();
        prog[RESET_PC + 4] = enc_jalr(imm);
        start_program(base, 0);
        next_fetch(RESET_PC);
        next_fetch(RESET_PC + 4);
        next_fetch(dest);
        next_fetch(dest + 4);
    endtask

    // Fetch must stay quiet until the unit reports its result.
    task automatic run_md(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] exp_res);
        int cycles;
        prog.delete();
        prog[RESET_PC] = enc_md(f3);
        start_program(a, b);
        next_fetch(RESET_PC);
        cycles = 0;
        do begin
            @(negedge clk);
            check_value("imem_req", {31'b0, imem_req}, 32'b0);
            cycles++;
            if (cycles == WAIT_LIMIT)
                timed_out("md_valid");
        end while (!md_valid);
        check_value("md_valid delay", cycles, `FE_MD_CYCLES + 1);
        check_value("md_result", md_result, exp_res);
        next_fetch(RESET_PC + 4);
    endtask

    task automatic test_sequential();
        prog.delete();
        start_program(0, 0);
        for (int i = 0; i < 12; i++)
            next_fetch(RESET_PC + 32'(4 * i));
    endtask

    task automatic test_jal_branch();
        run_jal(32'h40);
        run_jal(-32'sh100);
        run_jal(32'h1_0000);
        run_branch(3'b000, 5, 5, 32'h20, 1'b1);
        run_branch(3'b000, 5, 6, 32'h20, 1'b0);               // Not taken.
        run_branch(3'b001, 1, 2, -32'sh10, 1'b1);
        run_branch(3'b100, -32'sd5, 3, 32'h7fc, 1'b1);        // Signed compare.
        run_branch(3'b100, 3, -32'sd5, 32'h7fc, 1'b0);
        run_branch(3'b101, 3, -32'sd5, -32'sh800, 1'b1);
        run_branch(3'b101, 7, 7, 32'h40, 1'b1);
        run_branch(3'b101, -32'sd1, 0, 32'h40, 1'b0);
    endtask

    task automatic test_jalr();
        run_jalr(32'h8000_2001, 32'h10);
        run_jalr(32'h8000_0400, -32'sh20);
        run_jalr($urandom, 32'h7ff);
    endtask

    task automatic test_mul();
        logic [31:0] a;
        logic [31:0] b;
        run_md(3'b000, 32'hffff_fff9, 32'd9, 32'hffff_ffc1);  // -7 * 9.
        for (int i = 0; i < 3; i++) begin
            a = $urandom;
            b = $urandom;
            run_md(3'b000, a, b, a * b);
        end
    endtask

    task automatic test_divu();
        logic [31:0] a;
        logic [31:0] b;
        run_md(3'b101, 32'd100, 32'd7, 32'd14);
        for (int i = 0; i < 3; i++) begin
            a = $urandom;
            b = (i == 0) ? $urandom : $urandom_range(1000, 1);
            run_md(3'b101, a, b, a / b);
        end
        run_md(3'b101, $urandom, 32'd0, 32'hffff_ffff);  // Divide by zero.
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        imem_rdata  = '0;
        imem_rvalid = 1'b0;
        rs1_data    = '0;
        rs2_data    = '0;
        mem_busy    = 1'b0;
        mem_delay   = 0;
        void'($urandom(25555));
        test_sequential();
        test_jal_branch();
        test_jalr();
        test_mul();
        test_divu();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
fe_pkg.sv
fetch_if.sv
redirect_if.sv
pc_gen.sv
fetch_unit.sv
redirect_decode.sv
muldiv_seq.sv
fe_top.sv
tb_fe_top.sv
